//--- lc4_issue_stage.f
hdl/lc4_issue_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_dual_issue_ctrl.sv
hdl/lc4_issue_stage.sv
sim/lc4_issue_assertions.sv
sim/tb_lc4_issue_stage.sv

//--- Bender.yml
package:
  name: lc4_issue_stage

sources:
  - files:
      - hdl/lc4_issue_pkg.sv
      - hdl/lc4_decoder.sv
      - hdl/lc4_dual_issue_ctrl.sv
      - hdl/lc4_issue_stage.sv
  - target: simulation
    files:
      - sim/lc4_issue_assertions.sv
      - sim/tb_lc4_issue_stage.sv

//--- sim/tb_lc4_issue_stage.sv
`timescale 1ns/1ps

module tb_lc4_issue_stage;

    logic                      gwe;
    logic                      i_arst_n;
    lc4_issue_pkg::insn_t      i_insn_a;
    lc4_issue_pkg::insn_t      i_insn_b;
    lc4_issue_pkg::fetch_adv_t o_fetch_adv;
    lc4_issue_pkg::insn_t      o_x_insn_a;
    lc4_issue_pkg::insn_t      o_x_insn_b;
    lc4_issue_pkg::stall_e     o_stall_a;
    lc4_issue_pkg::stall_e     o_stall_b;

    lc4_issue_pkg::insn_t prog [0:63];   // program memory, NOP padded
    int          ptr;                    // fetch pointer
    int          value_errors;
    int          other_errors;
    logic [31:0] lfsr_state;

    // model copy of the decode and execute pairs
    lc4_issue_pkg::insn_t         m_da;
    lc4_issue_pkg::insn_t         m_db;
    lc4_issue_pkg::decoded_insn_t m_xa;
    lc4_issue_pkg::decoded_insn_t m_xb;
    lc4_issue_pkg::stall_e        m_sa;
    lc4_issue_pkg::stall_e        m_sb;
    int n_load_a;   // bubble codes seen on the DUT outputs in one run
    int n_load_b;
    int n_pipe_b;

    lc4_issue_stage u_dut (
        .gwe         (gwe),
        .i_arst_n    (i_arst_n),
        .i_insn_a    (i_insn_a),
        .i_insn_b    (i_insn_b),
        .o_fetch_adv (o_fetch_adv),
        .o_x_insn_a  (o_x_insn_a),
        .o_x_insn_b  (o_x_insn_b),
        .o_stall_a   (o_stall_a),
        .o_stall_b   (o_stall_b)
    );

    always #4 gwe = ~gwe;

    function automatic lc4_issue_pkg::insn_t add_word(input logic [2:0] d, input logic [2:0] s,
                                                      input logic [2:0] t);
        return {lc4_issue_pkg::OPC_ADD, d, s, 3'b000, t};
    endfunction
    function automatic lc4_issue_pkg::insn_t addi_word(input logic [2:0] d, input logic [2:0] s,
                                                       input logic [4:0] imm);
        return {lc4_issue_pkg::OPC_ADD, d, s, 1'b1, imm};
    endfunction
    function automatic lc4_issue_pkg::insn_t ldr_word(input logic [2:0] d, input logic [2:0] s);
        return {lc4_issue_pkg::OPC_LDR, d, s, 6'd0};
    endfunction
    function automatic lc4_issue_pkg::insn_t str_word(input logic [2:0] t, input logic [2:0] s);
        return {lc4_issue_pkg::OPC_STR, t, s, 6'd1};
    endfunction
    function automatic lc4_issue_pkg::insn_t const_word(input logic [2:0] d);
        return {lc4_issue_pkg::OPC_CONST, d, 9'h05a};
    endfunction

    // field use per opcode group as the ISA defines it
    function automatic lc4_issue_pkg::decoded_insn_t decode_word(input lc4_issue_pkg::insn_t w);
        lc4_issue_pkg::decoded_insn_t d;
        d      = '0;
        d.insn = w;
        if (w[15:12] == lc4_issue_pkg::OPC_ADD || w[15:12] == lc4_issue_pkg::OPC_LOGIC) begin
            d.wsel       = w[11:9];
            d.r1sel      = w[8:6];
            d.r2sel      = w[2:0];
            d.r1re       = 1'b1;
            d.r2re       = !w[5];   // immediate form skips rt
            d.regfile_we = 1'b1;
        end else if (w[15:12] == lc4_issue_pkg::OPC_LDR) begin
            d.wsel       = w[11:9];
            d.r1sel      = w[8:6];
            d.r1re       = 1'b1;
            d.regfile_we = 1'b1;
            d.is_load    = 1'b1;
        end else if (w[15:12] == lc4_issue_pkg::OPC_STR) begin
            d.r1sel    = w[8:6];
            d.r2sel    = w[11:9];
            d.r1re     = 1'b1;
            d.r2re     = 1'b1;
            d.is_store = 1'b1;
        end else if (w[15:12] == lc4_issue_pkg::OPC_CONST) begin
            d.wsel       = w[11:9];
            d.regfile_we = 1'b1;
        end
        return d;
    endfunction

    function automatic logic waits_on_load(input lc4_issue_pkg::decoded_insn_t x,
                                           input lc4_issue_pkg::decoded_insn_t d);
        logic r1_hit;
        logic r2_hit;
        r1_hit = d.r1re && (d.r1sel == x.wsel);
        r2_hit = d.r2re && (d.r2sel == x.wsel) && !d.is_store;
        return x.is_load && (r1_hit || r2_hit);
    endfunction

    function automatic logic pair_conflict(input lc4_issue_pkg::decoded_insn_t a,
                                           input lc4_issue_pkg::decoded_insn_t b);
        logic raw;
        logic mem;
        raw = a.regfile_we && ((b.r1re && b.r1sel == a.wsel) || (b.r2re && b.r2sel == a.wsel));
        mem = (a.is_load || a.is_store) && (b.is_load || b.is_store);
        return raw || mem;
    endfunction

    task automatic lfsr_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
    endtask

    task automatic compare_value(input string name, input logic [15:0] exp,
                                 input logic [15:0] got);
        if (exp !== got) begin
            value_errors++;
            $display("ERR %s exp=%h got=%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic expect_count(input int got, input int want, input string what);
        if (got != want) begin
            other_errors++;
            $display("expected %0d %s in this test but the DUT showed %0d", want, what, got);
        end
    endtask

    task automatic clear_program;
        for (int i = 0; i < 64; i++) begin
            prog[i] = lc4_issue_pkg::NOP_INSN;
        end
    endtask

    task automatic drive_fetch;
        i_insn_a = prog[ptr];
        i_insn_b = prog[ptr+1];
    endtask

    task automatic apply_reset;
        i_arst_n = 1'b0;
        ptr      = 0;
        m_da     = lc4_issue_pkg::NOP_INSN;
        m_db     = lc4_issue_pkg::NOP_INSN;
        m_xa     = '0;
        m_xb     = '0;
        m_sa     = lc4_issue_pkg::STALL_EMPTY;
        m_sb     = lc4_issue_pkg::STALL_EMPTY;
        n_load_a = 0;
        n_load_b = 0;
        n_pipe_b = 0;
        drive_fetch();
        repeat (8) @(posedge gwe);
        #1;
        i_arst_n = 1'b1;
    endtask

    // check this cycle at the falling edge, then advance model and fetch
    task automatic one_cycle;
        lc4_issue_pkg::decoded_insn_t da;
        lc4_issue_pkg::decoded_insn_t db;
        lc4_issue_pkg::decoded_insn_t nxa;
        lc4_issue_pkg::decoded_insn_t nxb;
        lc4_issue_pkg::stall_e        nsa;
        lc4_issue_pkg::stall_e        nsb;
        int                           adv;
        @(negedge gwe);
        da  = decode_word(m_da);
        db  = decode_word(m_db);
        nxa = da;
        nxb = db;
        nsa = lc4_issue_pkg::STALL_NONE;
        nsb = lc4_issue_pkg::STALL_NONE;
        adv = 2;
        if (waits_on_load(m_xa, da) || waits_on_load(m_xb, da)) begin
            nxa = '0;
            nxb = '0;
            nsa = lc4_issue_pkg::STALL_LOAD;
            nsb = lc4_issue_pkg::STALL_PIPE;
            adv = 0;
        end else if (waits_on_load(m_xa, db) || waits_on_load(m_xb, db)) begin
            nxb = '0;
            nsb = lc4_issue_pkg::STALL_LOAD;
            adv = 1;
        end else if (pair_conflict(da, db)) begin
            nxb = '0;
            nsb = lc4_issue_pkg::STALL_PIPE;
            adv = 1;
        end
        compare_value("o_fetch_adv", 16'(adv), 16'(o_fetch_adv));
        compare_value("o_x_insn_a", m_xa.insn, o_x_insn_a);
        compare_value("o_x_insn_b", m_xb.insn, o_x_insn_b);
        compare_value("o_stall_a", 16'(m_sa), 16'(o_stall_a));
        compare_value("o_stall_b", 16'(m_sb), 16'(o_stall_b));
        if (o_stall_a == lc4_issue_pkg::STALL_LOAD) begin
            n_load_a++;
        end
        if (o_stall_b == lc4_issue_pkg::STALL_LOAD) begin
            n_load_b++;
        end else if (o_stall_b == lc4_issue_pkg::STALL_PIPE &&
                     o_stall_a != lc4_issue_pkg::STALL_LOAD) begin
            n_pipe_b++;   // pair conflict, not the partner of a slot A load stall
        end
        @(posedge gwe);
        #1;
        if (adv == 2) begin
            m_da = prog[ptr];
            m_db = prog[ptr+1];
        end else if (adv == 1) begin
            m_da = m_db;       // held B moves up
            m_db = prog[ptr];
        end
        m_xa = nxa;
        m_xb = nxb;
        m_sa = nsa;
        m_sb = nsb;
        ptr  = ptr + adv;
        drive_fetch();
    endtask

    // run until every program word has passed through execute
    task automatic run_program(input int len);
        int cycles;
        apply_reset();
        cycles = 0;
        while (ptr < len + 4) begin
            if (cycles >= 4 * len + 20) begin
                other_errors++;
                $display("timeout, fetch pointer stuck at %0d of %0d", ptr, len);
                $display("%0d value errors, %0d other errors", value_errors, other_errors);
                $display("Verification failed");
                $finish;
            end else begin
                one_cycle();
                cycles++;
            end
        end
    endtask

    task automatic after_reset;
        clear_program();
        prog[0] = add_word(3'd1, 3'd2, 3'd3);
        prog[1] = const_word(3'd4);
        apply_reset();
        @(negedge gwe);
        compare_value("o_x_insn_a", lc4_issue_pkg::NOP_INSN, o_x_insn_a);
        compare_value("o_x_insn_b", lc4_issue_pkg::NOP_INSN, o_x_insn_b);
        compare_value("o_stall_a", 16'(lc4_issue_pkg::STALL_EMPTY), 16'(o_stall_a));
        compare_value("o_stall_b", 16'(lc4_issue_pkg::STALL_EMPTY), 16'(o_stall_b));
        compare_value("o_fetch_adv", 16'd2, 16'(o_fetch_adv));
        run_program(2);
    endtask

    task automatic independent_pair;
        clear_program();
        prog[0] = add_word(3'd1, 3'd2, 3'd3);
        prog[1] = add_word(3'd4, 3'd5, 3'd6);
        prog[2] = add_word(3'd3, 3'd4, 3'd5);
        prog[3] = addi_word(3'd6, 3'd1, 5'd3);   // imm low bits name r3
        run_program(4);
        expect_count(n_load_a + n_load_b + n_pipe_b, 0, "stalls");
    endtask

    task automatic pair_dependence;
        clear_program();
        prog[0] = add_word(3'd1, 3'd2, 3'd3);
        prog[1] = add_word(3'd4, 3'd1, 3'd5);
        prog[2] = add_word(3'd6, 3'd6, 3'd6);
        run_program(3);
        expect_count(n_pipe_b, 1, "B-slot pipe bubbles");
    endtask

    task automatic memory_port_conflict;
        clear_program();
        prog[0] = ldr_word(3'd1, 3'd2);
        prog[1] = str_word(3'd3, 3'd4);
        prog[2] = const_word(3'd5);
        run_program(3);
        expect_count(n_pipe_b, 1, "B-slot pipe bubbles");
    endtask

    task automatic load_use_on_a;
        clear_program();
        prog[0] = ldr_word(3'd1, 3'd2);
        prog[1] = add_word(3'd5, 3'd6, 3'd7);
        prog[2] = add_word(3'd3, 3'd1, 3'd4);
        prog[3] = const_word(3'd6);
        prog[4] = ldr_word(3'd2, 3'd3);
        prog[5] = add_word(3'd5, 3'd6, 3'd7);
        prog[6] = str_word(3'd2, 3'd4);   // loaded reg only as store data
        prog[7] = const_word(3'd7);
        run_program(8);
        expect_count(n_load_a, 1, "load-use stalls on slot A");
    endtask

    task automatic load_use_on_b;
        logic [15:0]            sel;
        logic [15:0]            rest;
        lc4_issue_pkg::opcode_t opc;
        clear_program();
        prog[0] = ldr_word(3'd1, 3'd2);
        prog[1] = const_word(3'd3);
        prog[2] = add_word(3'd4, 3'd5, 3'd6);
        prog[3] = add_word(3'd7, 3'd1, 3'd0);
        run_program(4);
        expect_count(n_load_b, 1, "load-use stalls on slot B");
        clear_program();
        for (int i = 0; i < 40; i++) begin
            lfsr_bits(3, sel);
            case (sel % 5)
                0:       opc = lc4_issue_pkg::OPC_ADD;
                1:       opc = lc4_issue_pkg::OPC_LOGIC;
                2:       opc = lc4_issue_pkg::OPC_LDR;
                3:       opc = lc4_issue_pkg::OPC_STR;
                default: opc = lc4_issue_pkg::OPC_CONST;
            endcase
            lfsr_bits(12, rest);
            prog[i] = {opc, rest[11:0]};
        end
        run_program(40);
    endtask

    initial begin
        gwe          = 1'b0;
        i_arst_n     = 1'b0;
        i_insn_a     = lc4_issue_pkg::NOP_INSN;
        i_insn_b     = lc4_issue_pkg::NOP_INSN;
        value_errors = 0;
        other_errors = 0;
        lfsr_state   = 32'd86166;
        after_reset();
        independent_pair();
        pair_dependence();
        memory_port_conflict();
        load_use_on_a();
        load_use_on_b();
        $display("%0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/lc4_issue_assertions.sv
`timescale 1ns/1ps

module lc4_issue_assertions (
    input logic                      gwe,
    input logic                      i_arst_n,
    input lc4_issue_pkg::fetch_adv_t i_fetch_adv,
    input lc4_issue_pkg::insn_t      i_x_insn_a,
    input lc4_issue_pkg::insn_t      i_x_insn_b,
    input lc4_issue_pkg::stall_e     i_stall_a,
    input lc4_issue_pkg::stall_e     i_stall_b
);

    // at most two fetch words per cycle
    adv_in_range: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_fetch_adv != 2'd3)
        else $error("fetch advance of 3 words");

    x_a_issued_clean: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_x_insn_a != '0) |-> (i_stall_a == lc4_issue_pkg::STALL_NONE))
        else $error("issued word in X-A carries a stall code");

    x_b_issued_clean: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_x_insn_b != '0) |-> (i_stall_b == lc4_issue_pkg::STALL_NONE))
        else $error("issued word in X-B carries a stall code");

    // single issue leaves a load or pipe bubble in B one cycle later
    single_issue_b_code: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_fetch_adv == 2'd1) |=> (i_stall_b == lc4_issue_pkg::STALL_LOAD ||
                                   i_stall_b == lc4_issue_pkg::STALL_PIPE))
        else $error("single issue without a B-slot bubble code");

endmodule

bind lc4_dual_issue_ctrl lc4_issue_assertions u_issue_assertions (
    .gwe         (gwe),
    .i_arst_n    (i_arst_n),
    .i_fetch_adv (o_fetch_adv),
    .i_x_insn_a  (o_x_insn_a),
    .i_x_insn_b  (o_x_insn_b),
    .i_stall_a   (o_stall_a),
    .i_stall_b   (o_stall_b)
);

//--- hdl/lc4_issue_stage.sv
`timescale 1ns/1ps

module lc4_issue_stage (
    input  logic                      gwe,          // pipeline clock
    input  logic                      i_arst_n,
    input  lc4_issue_pkg::insn_t      i_insn_a,     // fetch word at ptr
    input  lc4_issue_pkg::insn_t      i_insn_b,     // fetch word at ptr+1
    output lc4_issue_pkg::fetch_adv_t o_fetch_adv,
    output lc4_issue_pkg::insn_t      o_x_insn_a,
    output lc4_issue_pkg::insn_t      o_x_insn_b,
    output lc4_issue_pkg::stall_e     o_stall_a,
    output lc4_issue_pkg::stall_e     o_stall_b
);

    // decode pair leaving the controller
    lc4_issue_pkg::insn_t d_insn_a;
    lc4_issue_pkg::insn_t d_insn_b;

    // decoded records going back in
    lc4_issue_pkg::decoded_insn_t dec_a;
    lc4_issue_pkg::decoded_insn_t dec_b;

    // both slots are decoded in parallel
    lc4_decoder u_dec_a (
        .i_insn (d_insn_a),
        .o_dec  (dec_a)
    );

    lc4_decoder u_dec_b (
        .i_insn (d_insn_b),
        .o_dec  (dec_b)
    );

    lc4_dual_issue_ctrl u_ctrl (
        .gwe         (gwe),
        .i_arst_n    (i_arst_n),
        .i_insn_a    (i_insn_a),
        .i_insn_b    (i_insn_b),
        .i_dec_a     (dec_a),
        .i_dec_b     (dec_b),
        .o_d_insn_a  (d_insn_a),
        .o_d_insn_b  (d_insn_b),
        .o_fetch_adv (o_fetch_adv),
        .o_x_insn_a  (o_x_insn_a),
        .o_x_insn_b  (o_x_insn_b),
        .o_stall_a   (o_stall_a),
        .o_stall_b   (o_stall_b)
    );

endmodule

//--- hdl/lc4_dual_issue_ctrl.sv
`timescale 1ns/1ps

module lc4_dual_issue_ctrl (
    input  logic                         gwe,
    input  logic                         i_arst_n,
    input  lc4_issue_pkg::insn_t         i_insn_a,
    input  lc4_issue_pkg::insn_t         i_insn_b,
    input  lc4_issue_pkg::decoded_insn_t i_dec_a,
    input  lc4_issue_pkg::decoded_insn_t i_dec_b,
    output lc4_issue_pkg::insn_t         o_d_insn_a,
    output lc4_issue_pkg::insn_t         o_d_insn_b,
    output lc4_issue_pkg::fetch_adv_t    o_fetch_adv,
    output lc4_issue_pkg::insn_t         o_x_insn_a,
    output lc4_issue_pkg::insn_t         o_x_insn_b,
    output lc4_issue_pkg::stall_e        o_stall_a,
    output lc4_issue_pkg::stall_e        o_stall_b
);

    // decode pair
    lc4_issue_pkg::insn_t d_insn_a;
    lc4_issue_pkg::insn_t d_insn_b;

    // execute pair and its stall codes
    lc4_issue_pkg::decoded_insn_t x_a;
    lc4_issue_pkg::decoded_insn_t x_b;
    lc4_issue_pkg::stall_e        stall_a;
    lc4_issue_pkg::stall_e        stall_b;

    lc4_issue_pkg::decoded_insn_t x_a_nxt;
    lc4_issue_pkg::decoded_insn_t x_b_nxt;
    lc4_issue_pkg::stall_e        stall_a_nxt;
    lc4_issue_pkg::stall_e        stall_b_nxt;
    lc4_issue_pkg::fetch_adv_t    fetch_adv;

    logic lu_a;        // decode A waits on a load in X
    logic lu_b;        // decode B waits on a load in X
    logic b_needs_a;   // B reads what A writes
    logic mem_conf;    // only one memory port

    // a store's data operand is read late and does not count for load-use
    function automatic logic load_use(input lc4_issue_pkg::decoded_insn_t x,
                                      input lc4_issue_pkg::decoded_insn_t d);
        logic hit_r1;
        logic hit_r2;
        hit_r1 = d.r1re && (d.r1sel == x.wsel);
        hit_r2 = d.r2re && (d.r2sel == x.wsel) && !d.is_store;
        return x.is_load && (hit_r1 || hit_r2);
    endfunction

    assign lu_a = load_use(x_a, i_dec_a) || load_use(x_b, i_dec_a);
    assign lu_b = load_use(x_a, i_dec_b) || load_use(x_b, i_dec_b);

    assign b_needs_a = i_dec_a.regfile_we &&
                       ((i_dec_b.r1re && (i_dec_b.r1sel == i_dec_a.wsel)) ||
                        (i_dec_b.r2re && (i_dec_b.r2sel == i_dec_a.wsel)));
    assign mem_conf  = (i_dec_a.is_load || i_dec_a.is_store) &&
                       (i_dec_b.is_load || i_dec_b.is_store);

    always_comb begin
        // default is a full dual issue
        x_a_nxt     = i_dec_a;
        x_b_nxt     = i_dec_b;
        stall_a_nxt = lc4_issue_pkg::STALL_NONE;
        stall_b_nxt = lc4_issue_pkg::STALL_NONE;
        fetch_adv   = 2'd2;

        if (lu_a) begin
            x_a_nxt     = '0;
            x_b_nxt     = '0;
            stall_a_nxt = lc4_issue_pkg::STALL_LOAD;
            stall_b_nxt = lc4_issue_pkg::STALL_PIPE;
            fetch_adv   = 2'd0;
        end else if (lu_b) begin
            x_b_nxt     = '0;
            stall_b_nxt = lc4_issue_pkg::STALL_LOAD;
            fetch_adv   = 2'd1;
        end else if (b_needs_a || mem_conf) begin
            x_b_nxt     = '0;
            stall_b_nxt = lc4_issue_pkg::STALL_PIPE;
            fetch_adv   = 2'd1;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            d_insn_a <= lc4_issue_pkg::NOP_INSN;
            d_insn_b <= lc4_issue_pkg::NOP_INSN;
        end else begin
            case (fetch_adv)
                2'd2: begin
                    d_insn_a <= i_insn_a;
                    d_insn_b <= i_insn_b;
                end
                2'd1: begin
                    d_insn_a <= d_insn_b;   // held B moves up into slot A
                    d_insn_b <= i_insn_a;
                end
                default: begin
                    d_insn_a <= d_insn_a;
                    d_insn_b <= d_insn_b;
                end
            endcase
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_a     <= '0;
            x_b     <= '0;
            stall_a <= lc4_issue_pkg::STALL_EMPTY;
            stall_b <= lc4_issue_pkg::STALL_EMPTY;
        end else begin
            x_a     <= x_a_nxt;
            x_b     <= x_b_nxt;
            stall_a <= stall_a_nxt;
            stall_b <= stall_b_nxt;
        end
    end

    assign o_d_insn_a  = d_insn_a;
    assign o_d_insn_b  = d_insn_b;
    assign o_fetch_adv = fetch_adv;
    assign o_x_insn_a  = x_a.insn;
    assign o_x_insn_b  = x_b.insn;
    assign o_stall_a   = stall_a;
    assign o_stall_b   = stall_b;

endmodule

//--- hdl/lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder (
    input  lc4_issue_pkg::insn_t         i_insn,
    output lc4_issue_pkg::decoded_insn_t o_dec
);

    lc4_issue_pkg::opcode_t  opcode;
    lc4_issue_pkg::reg_sel_t wsel_f;
    lc4_issue_pkg::reg_sel_t r1sel_f;
    lc4_issue_pkg::reg_sel_t r2sel_f;

    assign opcode  = i_insn[lc4_issue_pkg::OPC_LSB +: lc4_issue_pkg::OPC_W];
    assign wsel_f  = i_insn[lc4_issue_pkg::WSEL_LSB +: lc4_issue_pkg::REG_SEL_W];
    assign r1sel_f = i_insn[lc4_issue_pkg::R1SEL_LSB +: lc4_issue_pkg::REG_SEL_W];
    assign r2sel_f = i_insn[lc4_issue_pkg::R2SEL_LSB +: lc4_issue_pkg::REG_SEL_W];

    always_comb begin
        // anything not listed below reads and writes nothing
        o_dec      = '0;
        o_dec.insn = i_insn;

        case (opcode)
            lc4_issue_pkg::OPC_ADD,
            lc4_issue_pkg::OPC_LOGIC: begin
                o_dec.wsel       = wsel_f;
                o_dec.r1sel      = r1sel_f;
                o_dec.r1re       = 1'b1;
                o_dec.regfile_we = 1'b1;
                // immediate form has no second source
                if (!i_insn[lc4_issue_pkg::IMM_BIT]) begin
                    o_dec.r2sel = r2sel_f;
                    o_dec.r2re  = 1'b1;
                end
            end

            lc4_issue_pkg::OPC_LDR: begin
                o_dec.wsel       = wsel_f;
                o_dec.r1sel      = r1sel_f;   // base address
                o_dec.r1re       = 1'b1;
                o_dec.regfile_we = 1'b1;
                o_dec.is_load    = 1'b1;
            end

            lc4_issue_pkg::OPC_STR: begin
                o_dec.r1sel    = r1sel_f;     // base address
                o_dec.r1re     = 1'b1;
                o_dec.r2sel    = wsel_f;      // store data lives in 11..9
                o_dec.r2re     = 1'b1;
                o_dec.is_store = 1'b1;
            end

            lc4_issue_pkg::OPC_CONST: begin
                o_dec.wsel       = wsel_f;
                o_dec.regfile_we = 1'b1;
            end

            default: ;
        endcase
    end

endmodule

//--- hdl/lc4_issue_pkg.sv
package lc4_issue_pkg;

    // isa field widths
    localparam int INSN_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int OPC_W     = 4;
    localparam int OPC_LSB   = 12;  // opcode sits in insn[15:12]
    localparam int ADV_W     = 2;

    typedef logic [INSN_W-1:0]    insn_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    typedef logic [OPC_W-1:0]     opcode_t;
    typedef logic [ADV_W-1:0]     fetch_adv_t;   // 0, 1 or 2 words

    // field positions inside the instruction word
    localparam int IMM_BIT   = 5;   // set selects the immediate form
    localparam int WSEL_LSB  = 9;   // rd, and the data reg of a store
    localparam int R1SEL_LSB = 6;   // rs
    localparam int R2SEL_LSB = 0;   // rt

    // opcodes handled by the decoder
    localparam opcode_t OPC_ADD   = 4'b0001;
    localparam opcode_t OPC_LOGIC = 4'b0101;
    localparam opcode_t OPC_LDR   = 4'b0110;
    localparam opcode_t OPC_STR   = 4'b0111;
    localparam opcode_t OPC_CONST = 4'b1001;

    localparam insn_t NOP_INSN = '0;

    // per-slot stall codes as seen in the execute stage
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_PIPE  = 2'd1,
        STALL_EMPTY = 2'd2,  // only the bubble left behind by reset
        STALL_LOAD  = 2'd3
    } stall_e;

    typedef struct packed {
        insn_t    insn;
        reg_sel_t r1sel;
        reg_sel_t r2sel;
        reg_sel_t wsel;
        logic     r1re;
        logic     r2re;
        logic     regfile_we;
        logic     is_load;
        logic     is_store;
    } decoded_insn_t;

endpackage
